// ==== Makefile ====
# Verilator build and run for the shopping basket controller

VERILATOR       ?= verilator
TOP             ?= tb_basket_controller
FILELIST        ?= verilog.f
BUILD_DIR       ?= obj_dir
LOG             ?= sim.log
VERILATOR_FLAGS ?= --binary --timing -j 0

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test build run clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables that can be overridden:"
	@echo "  VERILATOR=$(VERILATOR)"
	@echo "  TOP=$(TOP)"
	@echo "  FILELIST=$(FILELIST)"
	@echo "  BUILD_DIR=$(BUILD_DIR)"
	@echo "  LOG=$(LOG)"
	@echo "  VERILATOR_FLAGS=$(VERILATOR_FLAGS)"

build:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)

test: run
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "Test result: failure reported in $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "Simulation PASSED" $(LOG); then \
		echo "Test result: no pass line found in $(LOG)"; \
		exit 1; \
	fi
	@echo "Test result: ok"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/basket_checker.sv ====
//************************************************************
// Basket reference model and checker
//************************************************************

`timescale 1ns/10ps

module basket_checker #(
	parameter int SLOTS = 12
) (
	input  logic                                  CLK,
	input  logic                                  RESET_N,
	input  logic                                  add,
	input  logic                                  cancel,
	input  basket_pkg::product_id_t               product_id,
	input  basket_pkg::quantity_t                 quantity,
	input  basket_pkg::slot_idx_t                 cancel_slot,
	input  basket_pkg::basket_entry_t [SLOTS-1:0] entries,
	input  basket_pkg::slot_idx_t                 count,
	input  basket_pkg::price_t                    total_price,
	output int                                    error_count,
	output int                                    check_count
);

	basket_pkg::basket_entry_t model_entries [SLOTS];
	int                        model_count;
	basket_pkg::price_t        model_total;
	int                        cancel_idx;
	logic                      armed  = 1'b0;
	int                        errors = 0;
	int                        checks = 0;

	assign error_count = errors;
	assign check_count = checks;

	// Unit price 25 x (id + 1), times the quantity
	function automatic basket_pkg::price_t line_cost(basket_pkg::product_id_t id,
			basket_pkg::quantity_t qty);
		int unit_cost;
		unit_cost = 25 * (int'(id) + 1);
		return basket_pkg::price_t'(unit_cost * int'(qty));
	endfunction

	// Model steps on the same edge as the DUT, with the inputs held before it
	always @(posedge CLK) begin
		if (!RESET_N) begin
			for (int i = 0; i < SLOTS; i++) begin
				model_entries[i] = '1;
			end
			model_count = 0;
			model_total = '0;
			armed       = 1'b1;
		end else if (armed) begin
			cancel_idx = int'(cancel_slot);
			if (cancel && (cancel_idx < model_count)) begin
				model_total = model_total - model_entries[cancel_idx].line_price;
				for (int i = cancel_idx; i < SLOTS - 1; i++) begin
					model_entries[i] = model_entries[i + 1];
				end
				model_entries[SLOTS-1] = '1;
				model_count = model_count - 1;
			end else if (add && (model_count < SLOTS)) begin
				model_entries[model_count].product_id = product_id;
				model_entries[model_count].quantity   = quantity;
				model_entries[model_count].line_price = line_cost(product_id, quantity);
				model_total = model_total + line_cost(product_id, quantity);
				model_count = model_count + 1;
			end
		end
	end

	// Outputs are settled by the falling edge
	always @(negedge CLK) begin
		if (armed) begin
			checks = checks + 1;
			for (int i = 0; i < SLOTS; i++) begin
				if (entries[i] !== model_entries[i]) begin
					$display("CHECK FAILED: entries[%0d] expected %h got %h at %0t",
						i, model_entries[i], entries[i], $time);
					errors = errors + 1;
				end
			end
			if (count !== basket_pkg::slot_idx_t'(model_count)) begin
				$display("CHECK FAILED: count expected %h got %h at %0t",
					basket_pkg::slot_idx_t'(model_count), count, $time);
				errors = errors + 1;
			end
			if (total_price !== model_total) begin
				$display("CHECK FAILED: total_price expected %h got %h at %0t",
					model_total, total_price, $time);
				errors = errors + 1;
			end
		end
	end

endmodule

// ==== sim/tb_basket_controller.sv ====
//************************************************************
// Shopping basket controller testbench
//************************************************************

`timescale 1ns/10ps

module tb_basket_controller;

	localparam int SLOTS = 12;

	typedef struct packed {
		logic                    rst;
		logic                    add;
		logic                    cancel;
		basket_pkg::product_id_t product_id;
		basket_pkg::quantity_t   quantity;
		basket_pkg::slot_idx_t   slot;
	} step_t;

	logic                                  CLK;
	logic                                  RESET_N;
	logic                                  add;
	logic                                  cancel;
	basket_pkg::product_id_t               product_id;
	basket_pkg::quantity_t                 quantity;
	basket_pkg::slot_idx_t                 cancel_slot;
	basket_pkg::basket_entry_t [SLOTS-1:0] entries;
	basket_pkg::slot_idx_t                 count;
	basket_pkg::price_t                    total_price;
	int                                    error_count;
	int                                    check_count;
	int                                    cycle_limit;
	step_t                                 steps [$];

	basket_controller #(
		.SLOTS (SLOTS)
	) dut (
		.CLK         (CLK),
		.RESET_N     (RESET_N),
		.add         (add),
		.cancel      (cancel),
		.product_id  (product_id),
		.quantity    (quantity),
		.cancel_slot (cancel_slot),
		.entries     (entries),
		.count       (count),
		.total_price (total_price)
	);

	basket_checker #(
		.SLOTS (SLOTS)
	) u_checker (
		.CLK         (CLK),
		.RESET_N     (RESET_N),
		.add         (add),
		.cancel      (cancel),
		.product_id  (product_id),
		.quantity    (quantity),
		.cancel_slot (cancel_slot),
		.entries     (entries),
		.count       (count),
		.total_price (total_price),
		.error_count (error_count),
		.check_count (check_count)
	);

	function automatic step_t make_step(int rst, int add_s, int cancel_s, int id, int qty,
			int slot);
		step_t s;
		s.rst        = (rst != 0);
		s.add        = (add_s != 0);
		s.cancel     = (cancel_s != 0);
		s.product_id = basket_pkg::product_id_t'(id);
		s.quantity   = basket_pkg::quantity_t'(qty);
		s.slot       = basket_pkg::slot_idx_t'(slot);
		return s;
	endfunction

	task automatic build_table();
		// Appends of different products
		steps.push_back(make_step(0, 1, 0, 3, 2, 0));
		steps.push_back(make_step(0, 1, 0, 0, 1, 0));
		steps.push_back(make_step(0, 1, 0, 7, 3, 0));
		steps.push_back(make_step(0, 1, 0, 14, 15, 0));
		steps.push_back(make_step(0, 1, 0, 5, 4, 0));
		// Middle slot, then last slot, then first slot
		steps.push_back(make_step(0, 0, 1, 0, 0, 1));
		steps.push_back(make_step(0, 0, 1, 0, 0, 3));
		steps.push_back(make_step(0, 0, 1, 0, 0, 0));
		// Cancels at or past the count
		steps.push_back(make_step(0, 0, 1, 0, 0, 2));
		steps.push_back(make_step(0, 0, 1, 0, 0, 9));
		steps.push_back(make_step(0, 0, 1, 0, 0, 31));
		// Valid cancel beats a same cycle add
		steps.push_back(make_step(0, 1, 1, 1, 1, 0));
		// Out of range cancel lets the add through
		steps.push_back(make_step(0, 1, 1, 2, 2, 5));
		steps.push_back(make_step(0, 1, 0, 9, 0, 0));
		steps.push_back(make_step(1, 0, 0, 0, 0, 0));
		// Fill up so the total wraps past 16 bits
		for (int i = 0; i < SLOTS; i++) begin
			steps.push_back(make_step(0, 1, 0, 14, 15, 0));
		end
		steps.push_back(make_step(0, 1, 0, 1, 1, 0));
		steps.push_back(make_step(0, 0, 1, 0, 0, 12));
		steps.push_back(make_step(0, 1, 1, 0, 1, 11));
		steps.push_back(make_step(0, 1, 0, 2, 3, 0));
		steps.push_back(make_step(0, 0, 1, 0, 0, 4));
		steps.push_back(make_step(1, 0, 0, 0, 0, 0));
		steps.push_back(make_step(0, 1, 0, 6, 7, 0));
	endtask

	task automatic apply_step(step_t s);
		RESET_N     <= !s.rst;
		add         <= s.add;
		cancel      <= s.cancel;
		product_id  <= s.product_id;
		quantity    <= s.quantity;
		cancel_slot <= s.slot;
	endtask

	task automatic drive_idle();
		RESET_N <= 1'b1;
		add     <= 1'b0;
		cancel  <= 1'b0;
	endtask

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	initial begin
		RESET_N     = 1'b0;
		add         = 1'b0;
		cancel      = 1'b0;
		product_id  = '0;
		quantity    = '0;
		cancel_slot = '0;
		build_table();
		repeat (2) @(posedge CLK);
		RESET_N <= 1'b1;
		foreach (steps[i]) begin
			@(posedge CLK);
			apply_step(steps[i]);
			@(posedge CLK);
			drive_idle();
		end
		// Counts are read half a cycle after the last falling edge comparison
		repeat (2) @(posedge CLK);
		$display("Errors: %0d, checks: %0d", error_count, check_count);
		if (error_count == 0 && check_count > 0) begin
			$display("Simulation PASSED");
		end else begin
			if (check_count == 0) begin
				$display("No comparisons were made against the DUT");
			end
			$display("Simulation FAILED");
		end
		$finish;
	end

	// Two cycles per step plus reset and slack
	initial begin
		@(posedge CLK);
		cycle_limit = steps.size() * 2 + 10;
		repeat (cycle_limit) @(posedge CLK);
		$display("Timeout: the stimulus table did not finish within %0d cycles", cycle_limit);
		$display("Errors: %0d, checks: %0d", error_count, check_count);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== src/basket_controller.sv ====
//************************************************************
// Shopping basket controller
//************************************************************

`timescale 1ns/10ps

module basket_controller #(
	parameter int SLOTS = 12
) (
	input  logic                                  CLK,
	input  logic                                  RESET_N,
	input  logic                                  add,
	input  logic                                  cancel,
	input  basket_pkg::product_id_t               product_id,
	input  basket_pkg::quantity_t                 quantity,
	input  basket_pkg::slot_idx_t                 cancel_slot,
	output basket_pkg::basket_entry_t [SLOTS-1:0] entries,
	output basket_pkg::slot_idx_t                 count,
	output basket_pkg::price_t                    total_price
);

	basket_pkg::price_t        line_price;
	basket_pkg::basket_event_t basket_event;

	// Price of the product on the inputs, used by both list and total
	price_calculator u_price_calculator (
		.product_id (product_id),
		.quantity   (quantity),
		.line_price (line_price)
	);

	// Acceptance, full and range checks live only here
	basket_list #(
		.SLOTS (SLOTS)
	) u_basket_list (
		.CLK          (CLK),
		.RESET_N      (RESET_N),
		.add          (add),
		.cancel       (cancel),
		.product_id   (product_id),
		.quantity     (quantity),
		.line_price   (line_price),
		.cancel_slot  (cancel_slot),
		.entries      (entries),
		.count        (count),
		.basket_event (basket_event)
	);

	total_keeper u_total_keeper (
		.CLK          (CLK),
		.RESET_N      (RESET_N),
		.basket_event (basket_event),
		.line_price   (line_price),
		.total_price  (total_price)
	);

endmodule

// ==== src/basket_list.sv ====
//************************************************************
// Basket slot list
//************************************************************

`timescale 1ns/10ps

module basket_list #(
	parameter int SLOTS = 12
) (
	input  logic                                  CLK,
	input  logic                                  RESET_N,
	input  logic                                  add,
	input  logic                                  cancel,
	input  basket_pkg::product_id_t               product_id,
	input  basket_pkg::quantity_t                 quantity,
	input  basket_pkg::price_t                    line_price,
	input  basket_pkg::slot_idx_t                 cancel_slot,
	output basket_pkg::basket_entry_t [SLOTS-1:0] entries,
	output basket_pkg::slot_idx_t                 count,
	output basket_pkg::basket_event_t             basket_event
);

	localparam basket_pkg::slot_idx_t MAX_COUNT = basket_pkg::slot_idx_t'(SLOTS);
	localparam basket_pkg::slot_idx_t ONE       = basket_pkg::slot_idx_t'(1);

	logic                                  cancel_ok;
	logic                                  add_ok;
	basket_pkg::basket_entry_t             new_entry;
	basket_pkg::price_t                    removed_price;
	basket_pkg::basket_entry_t [SLOTS-1:0] entries_d;
	basket_pkg::slot_idx_t                 count_d;

	// Cancel only hits occupied slots, and an accepted cancel drops a same cycle add
	assign cancel_ok = cancel && (cancel_slot < count);
	assign add_ok    = add && !cancel_ok && (count < MAX_COUNT);

	always_comb begin
		new_entry.product_id = product_id;
		new_entry.quantity   = quantity;
		new_entry.line_price = line_price;
	end

	// Price of the line under cancel_slot
	always_comb begin
		removed_price = '0;
		for (int i = 0; i < SLOTS; i++) begin
			if (basket_pkg::slot_idx_t'(i) == cancel_slot) begin
				removed_price = entries[i].line_price;
			end
		end
	end

	// Event goes out in the strobe cycle so the total moves with the list
	always_comb begin
		basket_event.op            = basket_pkg::OP_NONE;
		basket_event.removed_price = '0;
		if (cancel_ok) begin
			basket_event.op            = basket_pkg::OP_CANCEL;
			basket_event.removed_price = removed_price;
		end else if (add_ok) begin
			basket_event.op = basket_pkg::OP_ADD;
		end
	end

	always_comb begin
		entries_d = entries;
		count_d   = count;
		if (cancel_ok) begin
			// Lines behind the cancelled slot move up by one
			for (int i = 0; i < SLOTS - 1; i++) begin
				if (basket_pkg::slot_idx_t'(i) >= cancel_slot) begin
					entries_d[i] = entries[i + 1];
				end
			end
			entries_d[SLOTS-1] = basket_pkg::EMPTY_ENTRY;
			count_d = count - ONE;
		end else if (add_ok) begin
			// Append at the first free slot
			for (int i = 0; i < SLOTS; i++) begin
				if (basket_pkg::slot_idx_t'(i) == count) begin
					entries_d[i] = new_entry;
				end
			end
			count_d = count + ONE;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RESET_N) begin
			entries <= {SLOTS{basket_pkg::EMPTY_ENTRY}};
			count   <= '0;
		end else begin
			entries <= entries_d;
			count   <= count_d;
		end
	end

endmodule

// ==== src/basket_pkg.sv ====
//************************************************************
// Shopping basket shared types
//************************************************************

package basket_pkg;

	// Field widths
	localparam int PRODUCT_ID_W = 4;
	localparam int QUANTITY_W   = 4;
	localparam int PRICE_W      = 16;
	localparam int SLOT_IDX_W   = 5;

	typedef logic [PRODUCT_ID_W-1:0] product_id_t;
	typedef logic [QUANTITY_W-1:0]   quantity_t;
	typedef logic [PRICE_W-1:0]      price_t;

	// Wide enough for a count of 16 lines
	typedef logic [SLOT_IDX_W-1:0]   slot_idx_t;

	// Id 15 is reserved for empty slots
	localparam product_id_t EMPTY_ID = '1;

	// Unit price of product p is 25 * (p + 1)
	localparam price_t unit_price_table [0:14] = '{
		16'd25,
		16'd50,
		16'd75,
		16'd100,
		16'd125,
		16'd150,
		16'd175,
		16'd200,
		16'd225,
		16'd250,
		16'd275,
		16'd300,
		16'd325,
		16'd350,
		16'd375
	};

	// One purchased line, 24 bits
	typedef struct packed {
		product_id_t product_id;
		quantity_t   quantity;
		price_t      line_price;
	} basket_entry_t;

	// Empty slot marker, all fields all ones
	localparam basket_entry_t EMPTY_ENTRY = '1;

	typedef enum logic [1:0] {
		OP_NONE   = 2'd0,
		OP_ADD    = 2'd1,
		OP_CANCEL = 2'd2
	} basket_op_e;

	// What the list accepted this cycle
	// removed_price only means something with OP_CANCEL
	typedef struct packed {
		basket_op_e op;
		price_t     removed_price;
	} basket_event_t;

endpackage

// ==== src/price_calculator.sv ====
//************************************************************
// Line price lookup
//************************************************************

`timescale 1ns/10ps

module price_calculator (
	input  basket_pkg::product_id_t product_id,
	input  basket_pkg::quantity_t   quantity,
	output basket_pkg::price_t      line_price
);

	basket_pkg::price_t unit_price;
	basket_pkg::price_t quantity_ext;

	// Empty marker id has no table entry and costs nothing
	always_comb begin
		if (product_id == basket_pkg::EMPTY_ID) begin
			unit_price = '0;
		end else begin
			unit_price = basket_pkg::unit_price_table[product_id];
		end
	end

	assign quantity_ext = basket_pkg::price_t'(quantity);

	// Largest line is 375 x 15, well inside 16 bits
	assign line_price = unit_price * quantity_ext;

endmodule

// ==== src/total_keeper.sv ====
//************************************************************
// Running basket total
//************************************************************

`timescale 1ns/10ps

module total_keeper (
	input  logic                      CLK,
	input  logic                      RESET_N,
	input  basket_pkg::basket_event_t basket_event,
	input  basket_pkg::price_t        line_price,
	output basket_pkg::price_t        total_price
);

	basket_pkg::price_t total_d;

	// Sums wrap at 16 bits
	always_comb begin
		case (basket_event.op)
			basket_pkg::OP_ADD:    total_d = total_price + line_price;
			basket_pkg::OP_CANCEL: total_d = total_price - basket_event.removed_price;
			default:               total_d = total_price;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RESET_N) begin
			total_price <= '0;
		end else begin
			total_price <= total_d;
		end
	end

endmodule

// ==== verilog.f ====
src/basket_pkg.sv
src/price_calculator.sv
src/basket_list.sv
src/total_keeper.sv
src/basket_controller.sv
sim/basket_checker.sv
sim/tb_basket_controller.sv
